/* usbTx.f */
hw/usbTxPkg.sv
hw/usbTxIf.sv
hw/usbCrc.sv
hw/usbBitStuffer.sv
hw/usbTx.sv
hw/usbTxConnection.sv
sim/usbTxTb.sv

/* sim/usbTxTb.sv */
`default_nettype none

module usbTxTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACCEPT_TIMEOUT = 24;
    localparam int END_TIMEOUT = 64;
    localparam int DRAIN_TIMEOUT = 16;

    logic       clk12;
    logic       rstN;
    logic       txReq;
    logic       txAccept;
    logic       txIsLast;
    logic       txValid;
    logic [7:0] txData;
    logic       usbDp;
    logic       usbDn;
    logic       sending;

    logic [15:0] lfsrState;
    logic [7:0]  expBytes[$];
    logic [7:0]  rxBytes[$];
    int          expLens[$];
    int          rxLens[$];
    int          packetsChecked;

    // Line decoder state.
    logic        inPacket;
    logic        prevLevel;
    logic        rxBit;
    logic [7:0]  curByte;
    int          onesRun;
    int          heldRun;
    int          se0Count;
    int          bitIdx;
    int          rxCount;

    usbTxConnection uut (
        .clk12_i           (clk12),
        .rstN_i            (rstN),
        .txReqSendPacket_i (txReq),
        .txAcceptNewData_o (txAccept),
        .txIsLastByte_i    (txIsLast),
        .txDataValid_i     (txValid),
        .txData_i          (txData),
        .USB_DP_o          (usbDp),
        .USB_DN_o          (usbDn),
        .sending_o         (sending)
    );

    initial begin
        clk12 = 1'b0;
        forever #50 clk12 = ~clk12;
    end

    task automatic reportMismatch(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic reportTimeout(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic checkByte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            reportMismatch($sformatf("%s is %02h, expected %02h", what, got, exp));
        end
    endtask

    task automatic checkPid(input usbTxPkg::usbPidByte_u got, input usbTxPkg::usbPidByte_u exp);
        if (got.fields.pid !== exp.fields.pid) begin
            reportMismatch($sformatf("PID nibble of byte %02h is %h, expected %h",
                                     got.raw, got.fields.pid, exp.fields.pid));
        end
        if (got.fields.check !== exp.fields.check) begin
            reportMismatch($sformatf("check nibble of PID byte %02h is %h, expected %h",
                                     got.raw, got.fields.check, exp.fields.check));
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            reportMismatch($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic takeRandom(input int nBits, output int unsigned value);
        int i;
        value = 0;
        for (i = 0; i < nBits; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = (value << 1) | lfsrState[0];
        end
    endtask

    // Byte-wise reflected CRC16 as software computes it.
    function automatic logic [15:0] crc16Ref(input logic [7:0] data[$]);
        logic [15:0] crc;
        int          k;
        int          b;
        crc = usbTxPkg::CRC16_INIT;
        for (k = 0; k < data.size(); k++) begin
            crc = crc ^ {8'h00, data[k]};
            for (b = 0; b < 8; b++) begin
                if (crc[0]) begin
                    crc = (crc >> 1) ^ usbTxPkg::CRC16_POLY;
                end else begin
                    crc = crc >> 1;
                end
            end
        end
        return crc;
    endfunction

    task automatic waitSending(input logic level, input string what);
        int n;
        n = 0;
        @(negedge clk12);
        while (sending !== level && n < END_TIMEOUT) begin
            @(negedge clk12);
            n++;
        end
        if (sending !== level) reportTimeout(what);
    endtask

    task automatic waitAccept(input string what);
        int n;
        n = 0;
        @(negedge clk12);
        while (txAccept !== 1'b1 && n < ACCEPT_TIMEOUT) begin
            @(negedge clk12);
            n++;
        end
        if (txAccept !== 1'b1) reportTimeout(what);
    endtask

    // Returns on the clock edge that starts the J bit after SE0.
    task automatic waitEopEnd(input string what);
        int n;
        n = 0;
        @(posedge clk12);
        while (se0Count != usbTxPkg::EOP_SE0_BITS && n < END_TIMEOUT) begin
            @(posedge clk12);
            n++;
        end
        if (se0Count != usbTxPkg::EOP_SE0_BITS) reportTimeout(what);
    endtask

    task automatic sendPacket(input logic [3:0] pid, input logic [7:0] payload[$],
                              input logic strayReq);
        usbTxPkg::usbPidByte_u pidByte;
        logic [7:0]            bytes[$];
        logic [15:0]           crc;
        int                    k;
        pidByte.fields.pid = pid;
        pidByte.fields.check = ~pid;
        bytes = payload;
        bytes.push_front(pidByte.raw);
        expBytes.push_back(usbTxPkg::SYNC_BYTE);
        for (k = 0; k < bytes.size(); k++) begin
            expBytes.push_back(bytes[k]);
        end
        if (pid == usbTxPkg::PID_DATA0 || pid == usbTxPkg::PID_DATA1) begin
            crc = ~crc16Ref(payload);
            expBytes.push_back(crc[7:0]);
            expBytes.push_back(crc[15:8]);
            expLens.push_back(bytes.size() + 3);
        end else begin
            expLens.push_back(bytes.size() + 1);
        end

        @(posedge clk12);
        txReq <= 1'b1;
        txData <= bytes[0];
        txIsLast <= (bytes.size() == 1);
        txValid <= 1'b1;
        @(posedge clk12);
        txReq <= 1'b0;
        @(negedge clk12);
        checkFlag(sending, 1'b1, "sending_o the cycle after the request");
        for (k = 0; k < bytes.size(); k++) begin
            waitAccept($sformatf("the accept of byte %0d", k));
            @(posedge clk12);
            if (k + 1 < bytes.size()) begin
                txData <= bytes[k + 1];
                txIsLast <= (k + 2 == bytes.size());
            end else begin
                txValid <= 1'b0;
                txIsLast <= 1'b0;
            end
            if (strayReq && k == 0) begin
                txReq <= 1'b1;
                @(posedge clk12);
                txReq <= 1'b0;
            end
        end
        if (strayReq) begin
            // Request during the closing J bit, while sending_o is still high.
            waitEopEnd("the end of SE0");
            txReq <= 1'b1;
            @(posedge clk12);
            txReq <= 1'b0;
        end
        waitSending(1'b0, "sending_o to fall after the EOP");
    endtask

    // NRZI decode, unstuff and byte assembly of the line.
    always @(negedge clk12) begin
        if (rstN && !sending) begin
            if (inPacket) reportMismatch("sending_o fell before the end of the packet");
            checkFlag(usbDp, 1'b1, "idle DP");
            checkFlag(usbDn, 1'b0, "idle DN");
            checkFlag(txAccept, 1'b0, "accept while idle");
        end else if (rstN) begin
            if (!inPacket) begin
                inPacket = 1'b1;
                prevLevel = 1'b1;
                onesRun = 0;
                heldRun = 0;
                se0Count = 0;
                bitIdx = 0;
                rxCount = 0;
            end
            if (!usbDp && !usbDn) begin
                se0Count++;
            end else if (se0Count > 0) begin
                checkFlag(usbDp, 1'b1, "DP of the J after SE0");
                checkFlag(usbDn, 1'b0, "DN of the J after SE0");
                if (se0Count != usbTxPkg::EOP_SE0_BITS) reportMismatch("wrong SE0 length");
                if (bitIdx != 0) reportMismatch("packet ended inside a byte");
                rxLens.push_back(rxCount);
                inPacket = 1'b0;
            end else begin
                checkFlag(usbDn, ~usbDp, "DN against DP");
                rxBit = (usbDp == prevLevel);
                prevLevel = usbDp;
                heldRun = rxBit ? heldRun + 1 : 0;
                if (heldRun > usbTxPkg::MAX_ONES) reportMismatch("line level held too long");
                if (onesRun == usbTxPkg::MAX_ONES) begin
                    checkFlag(rxBit, 1'b0, "stuffed bit");
                    onesRun = 0;
                end else begin
                    onesRun = rxBit ? onesRun + 1 : 0;
                    curByte[bitIdx] = rxBit;
                    bitIdx++;
                    if (bitIdx == 8) begin
                        rxBytes.push_back(curByte);
                        rxCount++;
                        bitIdx = 0;
                    end
                end
            end
        end
    end

    initial begin : comparePackets
        int         gotLen;
        int         expLen;
        int         i;
        logic [7:0] gotByte;
        logic [7:0] expByte;
        forever begin
            @(posedge clk12);
            if (rxLens.size() > 0) begin
                if (expLens.size() == 0) reportMismatch("packet on the line without a request");
                gotLen = rxLens.pop_front();
                expLen = expLens.pop_front();
                if (gotLen != expLen) begin
                    reportMismatch($sformatf("packet %0d has %0d bytes, expected %0d",
                                             packetsChecked, gotLen, expLen));
                end
                for (i = 0; i < expLen; i++) begin
                    gotByte = rxBytes.pop_front();
                    expByte = expBytes.pop_front();
                    if (i == 1) begin
                        checkPid(gotByte, expByte);
                    end else begin
                        checkByte(gotByte, expByte,
                                  $sformatf("packet %0d byte %0d", packetsChecked, i));
                    end
                end
                packetsChecked++;
            end
        end
    end

    initial begin : mainFlow
        logic [7:0]  payload[$];
        logic [3:0]  pid;
        int unsigned r;
        int          n;
        int          i;
        int          pkt;
        rstN = 1'b0;
        txReq = 1'b0;
        txIsLast = 1'b0;
        txValid = 1'b0;
        txData = 8'h00;
        inPacket = 1'b0;
        packetsChecked = 0;
        lfsrState = 16'd11530;
        repeat (16) @(posedge clk12);
        rstN <= 1'b1;

        // Quiet line after reset.
        repeat (6) begin
            @(negedge clk12);
            checkFlag(sending, 1'b0, "sending_o after reset");
            checkFlag(txAccept, 1'b0, "accept after reset");
            checkFlag(usbDp, 1'b1, "DP after reset");
        end

        sendPacket(usbTxPkg::PID_ACK, payload, 1'b0);

        takeRandom(4, r);
        n = r + 1;
        for (i = 0; i < n; i++) begin
            takeRandom(8, r);
            payload.push_back(r[7:0]);
        end
        sendPacket(usbTxPkg::PID_DATA0, payload, 1'b0);

        // All ones force the most stuffed bits.
        payload.delete();
        for (i = 0; i < 8; i++) begin
            payload.push_back(8'hFF);
        end
        sendPacket(usbTxPkg::PID_DATA1, payload, 1'b0);

        payload.delete();
        sendPacket(usbTxPkg::PID_DATA1, payload, 1'b0);

        for (pkt = 0; pkt < 20; pkt++) begin
            takeRandom(2, r);
            case (r)
                0: pid = usbTxPkg::PID_DATA0;
                1: pid = usbTxPkg::PID_DATA1;
                2: pid = usbTxPkg::PID_ACK;
                default: pid = usbTxPkg::PID_NAK;
            endcase
            payload.delete();
            if (r < 2) begin
                takeRandom(5, r);
                n = r % 17;
                for (i = 0; i < n; i++) begin
                    takeRandom(8, r);
                    payload.push_back(r[7:0]);
                end
            end
            takeRandom(1, r);
            sendPacket(pid, payload, r[0]);
        end

        n = 0;
        while (expLens.size() > 0 && n < DRAIN_TIMEOUT) begin
            @(negedge clk12);
            n++;
        end
        if (expLens.size() == 0 && rxLens.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Packets were left unchecked at the end of the run");
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* hw/usbTxConnection.sv */
`default_nettype none

module usbTxConnection (
    input  logic       clk12_i,
    input  logic       rstN_i,

    // Byte source, synchronous to clk12_i.
    input  logic       txReqSendPacket_i,
    output logic       txAcceptNewData_o,
    input  logic       txIsLastByte_i,
    input  logic       txDataValid_i,
    input  logic [7:0] txData_i,

    output logic       USB_DP_o,
    output logic       USB_DN_o,
    output logic       sending_o
);

    logic dataOutP;
    logic dataOutN;

    usbCrcIf crcIf ();
    usbBitStuffIf stuffIf ();

    usbCrc crcEngine (
        .clk12_i (clk12_i),
        .rstN_i  (rstN_i),
        .crcIf   (crcIf.engine)
    );

    usbBitStuffer bitStuffer (
        .clk12_i (clk12_i),
        .rstN_i  (rstN_i),
        .stuffIf (stuffIf.stuffer)
    );

    usbTx txEngine (
        .clk12_i           (clk12_i),
        .rstN_i            (rstN_i),
        .crcIf             (crcIf.tx),
        .stuffIf           (stuffIf.tx),
        .txReqSendPacket_i (txReqSendPacket_i),
        .txIsLastByte_i    (txIsLastByte_i),
        .txDataValid_i     (txDataValid_i),
        .txData_i          (txData_i),
        .txAcceptNewData_o (txAcceptNewData_o),
        .sending_o         (sending_o),
        .dataOutP_o        (dataOutP),
        .dataOutN_o        (dataOutN)
    );

    // Idle line is J.
    assign USB_DP_o = sending_o ? dataOutP : usbTxPkg::LINE_J_DP;
    assign USB_DN_o = sending_o ? dataOutN : usbTxPkg::LINE_J_DN;

endmodule

`default_nettype wire

/* hw/usbTx.sv */
`default_nettype none

module usbTx (
    input  logic       clk12_i,
    input  logic       rstN_i,

    usbCrcIf.tx        crcIf,
    usbBitStuffIf.tx   stuffIf,

    input  logic       txReqSendPacket_i,
    input  logic       txIsLastByte_i,
    input  logic       txDataValid_i,
    input  logic [7:0] txData_i,

    output logic       txAcceptNewData_o,
    output logic       sending_o,
    output logic       dataOutP_o,
    output logic       dataOutN_o
);

    logic [usbTxPkg::STATE_W-1:0]   state;
    logic [usbTxPkg::BIT_CNT_W-1:0] bitCnt;
    logic [7:0]                     shiftReg;
    usbTxPkg::usbPidByte_u          pidReg;
    logic                           lastByte;
    logic                           lineLevel;

    logic startPacket;
    logic advance;
    logic byteStart;
    logic curByteBit;
    logic txBit;
    logic isDataPid;
    logic nrziNext;
    logic sendBit;

    // The sequencer presents each bit one cycle before it reaches the line.
    assign startPacket = (state == usbTxPkg::ST_IDLE) && txReqSendPacket_i && !sending_o;
    assign advance = !stuffIf.holdBit;

    assign byteStart = ((state == usbTxPkg::ST_PID) || (state == usbTxPkg::ST_DATA))
                       && (bitCnt == 4'd0);
    assign txAcceptNewData_o = byteStart && advance;

    // First bit of a byte comes straight from the source as it is latched.
    assign curByteBit = byteStart ? txData_i[0] : shiftReg[0];

    assign isDataPid = (pidReg.fields.pid[1:0] == usbTxPkg::DATA_PID_LOW_BITS);

    always_comb begin
        case (state)
            usbTxPkg::ST_IDLE: txBit = usbTxPkg::SYNC_BYTE[0];
            usbTxPkg::ST_SYNC: txBit = shiftReg[0];
            usbTxPkg::ST_PID,
            usbTxPkg::ST_DATA: txBit = curByteBit;
            usbTxPkg::ST_CRC:  txBit = ~crcIf.crc[bitCnt];
            default:           txBit = 1'b0;
        endcase
    end

    assign stuffIf.restart = startPacket;
    assign stuffIf.dataIn = txBit;

    // Only payload bits enter the CRC.
    assign crcIf.restart = startPacket;
    assign crcIf.bitValid = (state == usbTxPkg::ST_DATA) && advance;
    assign crcIf.bitIn = curByteBit;

    // NRZI: a zero toggles the line.
    assign nrziNext = stuffIf.dataOut ? lineLevel : ~lineLevel;

    // Stuffed zero after the last CRC bit still goes out before SE0.
    assign sendBit = startPacket
                     || (state == usbTxPkg::ST_SYNC)
                     || (state == usbTxPkg::ST_PID)
                     || (state == usbTxPkg::ST_DATA)
                     || (state == usbTxPkg::ST_CRC)
                     || ((state == usbTxPkg::ST_EOP) && stuffIf.holdBit);

    always_ff @(posedge clk12_i) begin
        if (!rstN_i) begin
            lineLevel <= usbTxPkg::LINE_J_DP;
            dataOutP_o <= usbTxPkg::LINE_J_DP;
            dataOutN_o <= usbTxPkg::LINE_J_DN;
        end else if (sendBit) begin
            lineLevel <= nrziNext;
            dataOutP_o <= nrziNext;
            dataOutN_o <= ~nrziNext;
        end else if (state == usbTxPkg::ST_EOP) begin
            dataOutP_o <= usbTxPkg::LINE_SE0;
            dataOutN_o <= usbTxPkg::LINE_SE0;
        end else begin
            // J after SE0, and NRZI starts again from J.
            lineLevel <= usbTxPkg::LINE_J_DP;
            dataOutP_o <= usbTxPkg::LINE_J_DP;
            dataOutN_o <= usbTxPkg::LINE_J_DN;
        end
    end

    always_ff @(posedge clk12_i) begin
        if (!rstN_i) begin
            state <= usbTxPkg::ST_IDLE;
            bitCnt <= '0;
            sending_o <= 1'b0;
            lastByte <= 1'b0;
        end else begin
            if (txAcceptNewData_o) begin
                lastByte <= txIsLastByte_i;
            end

            case (state)
                usbTxPkg::ST_IDLE: begin
                    // Also ends the J bit of the previous packet.
                    sending_o <= startPacket;
                    if (startPacket) begin
                        state <= usbTxPkg::ST_SYNC;
                        bitCnt <= 4'd1;
                    end
                end

                usbTxPkg::ST_SYNC: begin
                    if (advance) begin
                        if (bitCnt == 4'd7) begin
                            state <= usbTxPkg::ST_PID;
                            bitCnt <= '0;
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                        end
                    end
                end

                usbTxPkg::ST_PID,
                usbTxPkg::ST_DATA: begin
                    if (advance) begin
                        if (bitCnt == 4'd7) begin
                            bitCnt <= '0;
                            if (!lastByte) begin
                                state <= usbTxPkg::ST_DATA;
                            end else if (isDataPid) begin
                                state <= usbTxPkg::ST_CRC;
                            end else begin
                                state <= usbTxPkg::ST_EOP;
                            end
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                        end
                    end
                end

                usbTxPkg::ST_CRC: begin
                    if (advance) begin
                        if (bitCnt == 4'd15) begin
                            state <= usbTxPkg::ST_EOP;
                            bitCnt <= '0;
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                        end
                    end
                end

                usbTxPkg::ST_EOP: begin
                    if (advance) begin
                        if (int'(bitCnt) == usbTxPkg::EOP_SE0_BITS - 1) begin
                            state <= usbTxPkg::ST_J;
                            bitCnt <= '0;
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                        end
                    end
                end

                default: begin
                    state <= usbTxPkg::ST_IDLE;
                end
            endcase
        end
    end

    // Byte shifter and latched PID.
    always_ff @(posedge clk12_i) begin
        if (startPacket) begin
            shiftReg <= usbTxPkg::SYNC_BYTE >> 1;
        end else if (txAcceptNewData_o) begin
            shiftReg <= {1'b0, txData_i[7:1]};
            if (state == usbTxPkg::ST_PID) begin
                pidReg.raw <= txData_i;
            end
        end else if (advance) begin
            shiftReg <= shiftReg >> 1;
        end
    end

    // The line cannot pause, so a missing byte is an underrun.
    noUnderrun: assert property (
        @(posedge clk12_i) disable iff (!rstN_i)
        txAcceptNewData_o |-> txDataValid_i
    ) else $error("usbTx: byte source underrun at accept");

endmodule

`default_nettype wire

/* hw/usbBitStuffer.sv */
`default_nettype none

module usbBitStuffer (
    input  logic          clk12_i,
    input  logic          rstN_i,
    usbBitStuffIf.stuffer stuffIf
);

    logic [usbTxPkg::ONES_CNT_W-1:0] onesCount;
    logic                            countClear;

    // Six ones seen, so this cycle carries the stuffed zero.
    assign stuffIf.holdBit = (int'(onesCount) == usbTxPkg::MAX_ONES);
    assign stuffIf.dataOut = stuffIf.holdBit ? 1'b0 : stuffIf.dataIn;

    // Any zero on the line breaks the run.
    assign countClear = stuffIf.restart || stuffIf.holdBit || !stuffIf.dataIn;

    always_ff @(posedge clk12_i) begin
        if (!rstN_i) begin
            onesCount <= '0;
        end else if (countClear) begin
            onesCount <= '0;
        end else begin
            onesCount <= onesCount + 1'b1;
        end
    end

    // The sender keeps its bit waiting behind the stuffed zero.
    holdKeepsBit: assert property (
        @(posedge clk12_i) disable iff (!rstN_i)
        stuffIf.holdBit |=> $stable(stuffIf.dataIn)
    ) else $error("usbBitStuffer: dataIn changed under a stuffed bit");

endmodule

`default_nettype wire

/* hw/usbCrc.sv */
`default_nettype none

module usbCrc (
    input  logic     clk12_i,
    input  logic     rstN_i,
    usbCrcIf.engine  crcIf
);

    logic [15:0] crcReg;
    logic [15:0] crcShifted;
    logic        feedback;

    // LSB-first update of the reflected register.
    assign feedback = crcReg[0] ^ crcIf.bitIn;
    assign crcShifted = {1'b0, crcReg[15:1]};

    always_ff @(posedge clk12_i) begin
        if (!rstN_i) begin
            crcReg <= usbTxPkg::CRC16_INIT;
        end else if (crcIf.restart) begin
            crcReg <= usbTxPkg::CRC16_INIT;
        end else if (crcIf.bitValid) begin
            if (feedback) begin
                crcReg <= crcShifted ^ usbTxPkg::CRC16_POLY;
            end else begin
                crcReg <= crcShifted;
            end
        end
    end

    assign crcIf.crc = crcReg;

    // Restart comes only at packet start, never alongside payload bits.
    restartNotWithBit: assert property (
        @(posedge clk12_i) disable iff (!rstN_i)
        !(crcIf.restart && crcIf.bitValid)
    ) else $error("usbCrc: restart and bitValid high in the same cycle");

endmodule

`default_nettype wire

/* hw/usbTxIf.sv */
`default_nettype none

interface usbCrcIf;
    logic        restart;
    logic        bitValid;
    logic        bitIn;
    logic [15:0] crc;

    modport tx (
        output restart,
        output bitValid,
        output bitIn,
        input  crc
    );

    modport engine (
        input  restart,
        input  bitValid,
        input  bitIn,
        output crc
    );
endinterface

interface usbBitStuffIf;
    logic restart;
    logic dataIn;
    logic dataOut;
    logic holdBit;

    modport tx (
        output restart,
        output dataIn,
        input  dataOut,
        input  holdBit
    );

    modport stuffer (
        input  restart,
        input  dataIn,
        output dataOut,
        output holdBit
    );
endinterface

`default_nettype wire

/* hw/usbTxPkg.sv */
`default_nettype none

package usbTxPkg;

    // Line levels.
    localparam logic LINE_J_DP = 1'b1;
    localparam logic LINE_J_DN = 1'b0;
    localparam logic LINE_SE0 = 1'b0;

    // Sent LSB first as KJKJKJKK.
    localparam logic [7:0] SYNC_BYTE = 8'h80;

    localparam logic [3:0] PID_DATA0 = 4'b0011;
    localparam logic [3:0] PID_DATA1 = 4'b1011;
    localparam logic [3:0] PID_ACK = 4'b0010;
    localparam logic [3:0] PID_NAK = 4'b1010;
    localparam logic [1:0] DATA_PID_LOW_BITS = 2'b11;

    // Reflected form of x^16 + x^15 + x^2 + 1.
    localparam logic [15:0] CRC16_POLY = 16'hA001;
    localparam logic [15:0] CRC16_INIT = 16'hFFFF;

    localparam int MAX_ONES = 6;
    localparam int EOP_SE0_BITS = 2;
    localparam int ONES_CNT_W = $clog2(MAX_ONES + 1);
    localparam int BIT_CNT_W = 4;

    // Sequencer states.
    localparam int STATE_W = 3;
    localparam logic [STATE_W-1:0] ST_IDLE = 3'd0;
    localparam logic [STATE_W-1:0] ST_SYNC = 3'd1;
    localparam logic [STATE_W-1:0] ST_PID = 3'd2;
    localparam logic [STATE_W-1:0] ST_DATA = 3'd3;
    localparam logic [STATE_W-1:0] ST_CRC = 3'd4;
    localparam logic [STATE_W-1:0] ST_EOP = 3'd5;
    localparam logic [STATE_W-1:0] ST_J = 3'd6;

    // Upper nibble is the complement of the PID.
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] check;
            logic [3:0] pid;
        } fields;
    } usbPidByte_u;

endpackage

`default_nettype wire
